// ==== Bender.yml ====
package:
  name: exu

sources:
  - rtl/exu_pkg.sv
  - rtl/operand_select.sv
  - rtl/alu.sv
  - rtl/branch_resolve.sv
  - rtl/bpu_stats.sv
  - rtl/exu.sv
  - rtl/exu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_exu.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  exu_pkg::alu_op_e op_i,
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  output exu_pkg::word_t   res_o,
  output logic             cmp_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic       is_cmp;

  assign shamt = b_i[4:0];  // rv32 shifts ignore the upper bits
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);

  // branch compares
  always_comb begin
    is_cmp = 1'b1;
    case (op_i)
      ALU_BEQ:  cmp_o = eq;
      ALU_BNE:  cmp_o = ~eq;
      ALU_BLT:  cmp_o = lt_s;
      ALU_BGE:  cmp_o = ~lt_s;
      ALU_BLTU: cmp_o = lt_u;
      ALU_BGEU: cmp_o = ~lt_u;
      default: begin
        is_cmp = 1'b0;
        cmp_o  = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $signed(a_i) >>> shamt;  // sign fill
      ALU_SLT:  res_o = word_t'(lt_s);
      ALU_SLTU: res_o = word_t'(lt_u);
      default:  res_o = '0;
    endcase

    // branches report the flag as a zero-extended word
    if (is_cmp) begin
      res_o = word_t'(cmp_o);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bpu_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_stats (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           cfg_we_i,
  input  logic           cfg_check_en_i,
  input  logic           stats_clear_i,
  input  logic           bpu_valid_i,
  input  logic           correct_i,
  output logic           check_en_o,
  output exu_pkg::word_t branch_count_o,
  output exu_pkg::word_t mispredict_count_o
);

  logic branch_inc;
  logic mispredict_inc;

  // saturate at all ones
  assign branch_inc     = bpu_valid_i & (branch_count_o != '1);
  assign mispredict_inc = bpu_valid_i & ~correct_i & (mispredict_count_o != '1);

  // predictor checking is on out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      check_en_o <= 1'b1;
    end else if (cfg_we_i) begin
      check_en_o <= cfg_check_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || stats_clear_i) begin  // clear beats a same-cycle count
      branch_count_o     <= '0;
      mispredict_count_o <= '0;
    end else begin
      if (branch_inc) begin
        branch_count_o <= branch_count_o + 1'b1;
      end
      if (mispredict_inc) begin
        mispredict_count_o <= mispredict_count_o + 1'b1;
      end
    end
  end

  // every miss is also a counted branch
  a_miss_le_branch: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mispredict_count_o <= branch_count_o
  ) else $error("mispredict count above branch count");

endmodule

`default_nettype wire

// ==== rtl/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  exu_pkg::exc_op_e     exc_op_i,
  input  exu_pkg::word_t       pc_i,
  input  exu_pkg::word_t       rs1_i,
  input  exu_pkg::word_t       imm_i,
  input  logic                 cmp_i,
  input  logic                 pdt_taken_i,
  input  exu_pkg::word_t       pdt_tag_i,
  input  logic                 check_en_i,
  output logic                 is_cf_o,
  output exu_pkg::bpu_update_t update_o,
  output logic                 redirect_o,
  output exu_pkg::word_t       redirect_pc_o
);
  import exu_pkg::*;

  logic       is_jal;
  logic       is_jalr;
  logic       is_branch;
  logic       taken;
  logic       pdt_eff;
  logic       correct;
  jump_type_e jump_type;
  word_t      pc_imm;
  word_t      rs1_imm;
  word_t      pc_plus4;
  word_t      jump_target;

  assign is_jal    = (exc_op_i == EXC_JAL);
  assign is_jalr   = (exc_op_i == EXC_JALR);
  assign is_branch = (exc_op_i == EXC_BRANCH);
  assign is_cf_o   = is_jal | is_jalr | is_branch;

  // jumps always go, branches follow the compare
  assign taken = is_jal | is_jalr | (is_branch & cmp_i);

  // a taken guess counts only when its tag hits this pc
  assign pdt_eff = pdt_taken_i & (pdt_tag_i == pc_i);

  // only the direction counts for jalr
  assign correct = (taken == pdt_eff);

  // target adders kept apart from the alu
  assign pc_imm      = pc_i + imm_i;
  assign rs1_imm     = rs1_i + imm_i;
  assign pc_plus4    = pc_i + word_t'(4);
  assign jump_target = is_jalr ? {rs1_imm[XLEN-1:1], 1'b0} : pc_imm;

  always_comb begin
    if (is_jal) begin
      jump_type = JT_JAL;
    end else if (is_jalr) begin
      jump_type = JT_JALR;
    end else if (is_branch) begin
      jump_type = JT_BRANCH;
    end else begin
      jump_type = JT_NONE;
    end
  end

  assign update_o = '{
    taken:     taken,
    correct:   correct,
    jump_type: jump_type,
    pc:        pc_i,
    target:    jump_target
  };

  // non-control ops are never taken, so a hit taken guess on one is also wrong
  assign redirect_o    = check_en_i & ~correct;
  assign redirect_pc_o = (pdt_eff & ~taken) ? pc_plus4 : jump_target;

endmodule

`default_nettype wire

// ==== rtl/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu #(
  parameter int HIST_LEN = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  input  logic                 pdt_taken_i,
  input  exu_pkg::word_t       pdt_tag_i,
  input  logic                 which_pdt_i,
  input  logic [HIST_LEN-1:0]  history_i,
  input  logic                 check_en_i,
  output logic                 result_valid_o,
  output exu_pkg::exu_result_t result_o,
  output logic                 bpu_valid_o,
  output exu_pkg::bpu_update_t bpu_o,
  output logic                 which_pdt_o,
  output logic [HIST_LEN-1:0]  history_o,
  output logic                 redirect_valid_o,
  output exu_pkg::word_t       redirect_pc_o
);
  import exu_pkg::*;

  alu_op_e     alu_op;
  word_t       opa;
  word_t       opb;
  word_t       alu_res;
  logic        cmp;
  logic        is_cf;
  logic        redirect;
  word_t       redirect_pc;
  bpu_update_t update;
  exu_result_t result_d;

  // link, upper-immediate and address classes just add their operand pair
  always_comb begin
    case (issue_i.exc_op)
      EXC_OPREG, EXC_OPIMM, EXC_BRANCH, EXC_NONE: alu_op = issue_i.alu_op;
      default:                                    alu_op = ALU_ADD;
    endcase
  end

  operand_select u_operand_select (
    .exc_op_i (issue_i.exc_op),
    .pc_i     (issue_i.pc),
    .rs1_i    (issue_i.rs1_data),
    .rs2_i    (issue_i.rs2_data),
    .imm_i    (issue_i.imm),
    .opa_o    (opa),
    .opb_o    (opb)
  );

  alu u_alu (
    .op_i  (alu_op),
    .a_i   (opa),
    .b_i   (opb),
    .res_o (alu_res),
    .cmp_o (cmp)
  );

  branch_resolve u_branch_resolve (
    .exc_op_i      (issue_i.exc_op),
    .pc_i          (issue_i.pc),
    .rs1_i         (issue_i.rs1_data),
    .imm_i         (issue_i.imm),
    .cmp_i         (cmp),
    .pdt_taken_i   (pdt_taken_i),
    .pdt_tag_i     (pdt_tag_i),
    .check_en_i    (check_en_i),
    .is_cf_o       (is_cf),
    .update_o      (update),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  assign result_d = '{
    pc:       issue_i.pc,
    inst:     issue_i.inst,
    rd:       issue_i.rd,
    rs2_data: issue_i.rs2_data,
    alu_data: alu_res,
    mem_op:   issue_i.mem_op
  };

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_o   <= 1'b0;
      bpu_valid_o      <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      result_valid_o   <= issue_valid_i;
      bpu_valid_o      <= issue_valid_i & is_cf;     // jal, jalr, branch
      redirect_valid_o <= issue_valid_i & redirect;
    end
  end

  // payload only moves on the strobe
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      result_o      <= result_d;
      bpu_o         <= update;
      which_pdt_o   <= which_pdt_i;
      history_o     <= history_i;
      redirect_pc_o <= redirect_pc;
    end
  end

  a_redirect_with_result: assert property (
    @(posedge clk_i) disable iff (rst_i)
    redirect_valid_o |-> result_valid_o
  ) else $error("redirect without a result");

  a_bpu_with_result: assert property (
    @(posedge clk_i) disable iff (rst_i)
    bpu_valid_o |-> result_valid_o
  ) else $error("predictor feedback without a result");

endmodule

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;     // data or address word
  typedef logic [4:0]      reg_idx_t;  // register index
  typedef logic [2:0]      mem_op_t;   // decoded by the memory stage only

  // instruction class from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_BRANCH = 4'd5,
    EXC_LOAD   = 4'd6,
    EXC_STORE  = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9
  } exc_op_e;

  // ten arithmetic codes followed by the six branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    alu_op_e  alu_op;
    mem_op_t  mem_op;
    exc_op_e  exc_op;
  } exu_issue_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    reg_idx_t rd;
    word_t    rs2_data;  // store data
    word_t    alu_data;
    mem_op_t  mem_op;
  } exu_result_t;

  // predictor feedback for one control-flow op
  typedef struct packed {
    logic       taken;
    logic       correct;
    jump_type_e jump_type;
    word_t      pc;
    word_t      target;  // taken target even when not taken
  } bpu_update_t;

endpackage

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top #(
  parameter int HIST_LEN = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_valid_i,
  input  exu_pkg::exu_issue_t  issue_i,
  input  logic                 pdt_taken_i,
  input  exu_pkg::word_t       pdt_tag_i,
  input  logic                 which_pdt_i,
  input  logic [HIST_LEN-1:0]  history_i,
  input  logic                 cfg_we_i,
  input  logic                 cfg_check_en_i,
  input  logic                 stats_clear_i,
  output logic                 result_valid_o,
  output exu_pkg::exu_result_t result_o,
  output logic                 bpu_valid_o,
  output exu_pkg::bpu_update_t bpu_o,
  output logic                 which_pdt_o,
  output logic [HIST_LEN-1:0]  history_o,
  output logic                 redirect_valid_o,
  output exu_pkg::word_t       redirect_pc_o,
  output exu_pkg::word_t       branch_count_o,
  output exu_pkg::word_t       mispredict_count_o
);

  logic check_en;  // 0 lets every op resolve silently

  exu #(
    .HIST_LEN (HIST_LEN)
  ) u_exu (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .issue_valid_i    (issue_valid_i),
    .issue_i          (issue_i),
    .pdt_taken_i      (pdt_taken_i),
    .pdt_tag_i        (pdt_tag_i),
    .which_pdt_i      (which_pdt_i),
    .history_i        (history_i),
    .check_en_i       (check_en),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o),
    .bpu_valid_o      (bpu_valid_o),
    .bpu_o            (bpu_o),
    .which_pdt_o      (which_pdt_o),
    .history_o        (history_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  bpu_stats u_bpu_stats (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .cfg_we_i           (cfg_we_i),
    .cfg_check_en_i     (cfg_check_en_i),
    .stats_clear_i      (stats_clear_i),
    .bpu_valid_i        (bpu_valid_o),
    .correct_i          (bpu_o.correct),
    .check_en_o         (check_en),
    .branch_count_o     (branch_count_o),
    .mispredict_count_o (mispredict_count_o)
  );

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select (
  input  exu_pkg::exc_op_e exc_op_i,
  input  exu_pkg::word_t   pc_i,
  input  exu_pkg::word_t   rs1_i,
  input  exu_pkg::word_t   rs2_i,
  input  exu_pkg::word_t   imm_i,
  output exu_pkg::word_t   opa_o,
  output exu_pkg::word_t   opb_o
);
  import exu_pkg::*;

  word_t imm_upper;

  // lui/auipc use the top 20 bits only
  assign imm_upper = {imm_i[XLEN-1:12], 12'b0};

  always_comb begin
    case (exc_op_i)
      EXC_OPIMM, EXC_LOAD, EXC_STORE: begin
        opa_o = rs1_i;
        opb_o = imm_i;  // shamt sits in imm[4:0]
      end
      EXC_JAL, EXC_JALR: begin
        // link address
        opa_o = pc_i;
        opb_o = word_t'(4);
      end
      EXC_AUIPC: begin
        opa_o = pc_i;
        opb_o = imm_upper;
      end
      EXC_LUI: begin
        opa_o = '0;
        opb_o = imm_upper;
      end
      default: begin
        // opreg, branch compare, none
        opa_o = rs1_i;
        opb_o = rs2_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+test
rtl/exu_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/branch_resolve.sv
rtl/bpu_stats.sv
rtl/exu.sv
rtl/exu_top.sv
test/tb_exu.sv

// ==== test/tb_exu_ref.svh ====
`ifndef TB_EXU_REF_SVH
`define TB_EXU_REF_SVH
`default_nettype none

// branch compare per the rv32i definitions
function automatic logic ref_cmp(input exu_pkg::alu_op_e op,
                                 input exu_pkg::word_t a, input exu_pkg::word_t b);
  logic eq;
  logic ltu;
  logic lts;
  eq  = (a == b);
  ltu = (a < b);
  lts = (a[31] != b[31]) ? a[31] : ltu;  // differing signs decide alone
  case (op)
    exu_pkg::ALU_BEQ:  return eq;
    exu_pkg::ALU_BNE:  return !eq;
    exu_pkg::ALU_BLT:  return lts;
    exu_pkg::ALU_BGE:  return !lts;
    exu_pkg::ALU_BLTU: return ltu;
    exu_pkg::ALU_BGEU: return !ltu;
    default:           return 1'b0;
  endcase
endfunction

function automatic exu_pkg::word_t ref_arith(input exu_pkg::alu_op_e op,
                                             input exu_pkg::word_t a, input exu_pkg::word_t b);
  logic [63:0] ext;
  ext = {{32{a[31]}}, a} >> b[4:0];  // arithmetic shift via sign extension
  case (op)
    exu_pkg::ALU_ADD:  return a + b;
    exu_pkg::ALU_SUB:  return a - b;
    exu_pkg::ALU_AND:  return a & b;
    exu_pkg::ALU_OR:   return a | b;
    exu_pkg::ALU_XOR:  return a ^ b;
    exu_pkg::ALU_SLL:  return a << b[4:0];
    exu_pkg::ALU_SRL:  return a >> b[4:0];
    exu_pkg::ALU_SRA:  return ext[31:0];
    exu_pkg::ALU_SLT:  return {31'b0, ref_cmp(exu_pkg::ALU_BLT, a, b)};
    exu_pkg::ALU_SLTU: return {31'b0, ref_cmp(exu_pkg::ALU_BLTU, a, b)};
    default:           return {31'b0, ref_cmp(op, a, b)};
  endcase
endfunction

// alu data word handed to the memory stage
function automatic exu_pkg::word_t ref_alu(input exu_pkg::exc_op_e exc,
                                           input exu_pkg::alu_op_e op, input exu_pkg::word_t pc,
                                           input exu_pkg::word_t rs1, input exu_pkg::word_t rs2,
                                           input exu_pkg::word_t imm);
  exu_pkg::word_t upper;
  upper = {imm[31:12], 12'h000};
  case (exc)
    exu_pkg::EXC_LUI:                    return upper;
    exu_pkg::EXC_AUIPC:                  return pc + upper;
    exu_pkg::EXC_JAL, exu_pkg::EXC_JALR: return pc + 32'd4;  // link
    exu_pkg::EXC_LOAD, exu_pkg::EXC_STORE: return rs1 + imm;
    exu_pkg::EXC_OPIMM:                  return ref_arith(op, rs1, imm);
    default:                             return ref_arith(op, rs1, rs2);
  endcase
endfunction

function automatic logic ref_taken(input exu_pkg::exc_op_e exc, input exu_pkg::alu_op_e op,
                                   input exu_pkg::word_t rs1, input exu_pkg::word_t rs2);
  if (exc == exu_pkg::EXC_JAL || exc == exu_pkg::EXC_JALR) begin
    return 1'b1;
  end
  return (exc == exu_pkg::EXC_BRANCH) && ref_cmp(op, rs1, rs2);
endfunction

function automatic exu_pkg::jump_type_e ref_jump_type(input exu_pkg::exc_op_e exc);
  case (exc)
    exu_pkg::EXC_JAL:    return exu_pkg::JT_JAL;
    exu_pkg::EXC_JALR:   return exu_pkg::JT_JALR;
    exu_pkg::EXC_BRANCH: return exu_pkg::JT_BRANCH;
    default:             return exu_pkg::JT_NONE;
  endcase
endfunction

// taken target where jalr drops bit 0
function automatic exu_pkg::word_t ref_target(input exu_pkg::exc_op_e exc,
                                              input exu_pkg::word_t pc, input exu_pkg::word_t rs1,
                                              input exu_pkg::word_t imm);
  exu_pkg::word_t sum;
  sum = rs1 + imm;
  if (exc == exu_pkg::EXC_JALR) begin
    return {sum[31:1], 1'b0};
  end
  return pc + imm;
endfunction

function automatic logic ref_redirect(input exu_pkg::exc_op_e exc, input logic taken,
                                      input logic pdt_eff, input logic check_en);
  if (!check_en) begin
    return 1'b0;
  end
  if (ref_jump_type(exc) != exu_pkg::JT_NONE) begin
    return taken != pdt_eff;
  end
  return pdt_eff;  // hit taken guess on a plain op
endfunction

`default_nettype wire
`endif

// ==== test/tb_exu.sv ====
`timescale 1ns/1ps
`include "tb_exu_ref.svh"
`default_nettype none

module tb_exu;
  import exu_pkg::*;

  localparam int HIST_LEN   = 8;
  localparam int CLK_PERIOD = 100;
  localparam int N_RAND     = 300;
  localparam int N_OFF      = 60;   // issues with checking disabled
  localparam int NUM_ISSUES = N_RAND + N_OFF + 8;

  typedef logic [HIST_LEN-1:0] hist_t;

  typedef struct packed {
    logic [31:0] cyc;  // cycle of the issue
    exu_result_t result;
    logic        bpu_valid;
    bpu_update_t bpu;
    logic        which_pdt;
    hist_t       history;
    logic        redirect;
    word_t       redirect_pc;
  } expect_t;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        issue_valid_i;
  exu_issue_t  issue_i;
  logic        pdt_taken_i;
  word_t       pdt_tag_i;
  logic        which_pdt_i;
  hist_t       history_i;
  logic        cfg_we_i;
  logic        cfg_check_en_i;
  logic        stats_clear_i;
  logic        result_valid_o;
  exu_result_t result_o;
  logic        bpu_valid_o;
  bpu_update_t bpu_o;
  logic        which_pdt_o;
  hist_t       history_o;
  logic        redirect_valid_o;
  word_t       redirect_pc_o;
  word_t       branch_count_o;
  word_t       mispredict_count_o;

  expect_t     exp_q[$];
  logic [31:0] cyc = '0;
  logic [31:0] lfsr_state = 32'hce87;
  logic        check_en_exp = 1'b1;
  word_t       branch_tally = '0;
  word_t       miss_tally = '0;
  int          n_checks = 0;
  int          n_errors = 0;

  exu_top #(
    .HIST_LEN (HIST_LEN)
  ) DUT (
    .clk_i, .rst_i, .issue_valid_i, .issue_i, .pdt_taken_i, .pdt_tag_i, .which_pdt_i,
    .history_i, .cfg_we_i, .cfg_check_en_i, .stats_clear_i, .result_valid_o, .result_o,
    .bpu_valid_o, .bpu_o, .which_pdt_o, .history_o, .redirect_valid_o, .redirect_pc_o,
    .branch_count_o, .mispredict_count_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_word(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [135:0] exp, input logic [135:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // drives one issue at a falling edge and returns at the next one
  task automatic issue_op(input exc_op_e exc, input alu_op_e op, input word_t pc,
                          input word_t rs1, input word_t rs2, input word_t imm,
                          input logic pdt_taken, input word_t tag);
    expect_t e;
    logic    taken;
    logic    pdt_eff;
    logic    cf;
    issue_valid_i    = 1'b1;
    issue_i.pc       = pc;
    issue_i.inst     = rand_word(32);
    issue_i.rd       = reg_idx_t'(rand_word(5));
    issue_i.rs1_data = rs1;
    issue_i.rs2_data = rs2;
    issue_i.imm      = imm;
    issue_i.alu_op   = op;
    issue_i.mem_op   = mem_op_t'(rand_word(3));
    issue_i.exc_op   = exc;
    pdt_taken_i      = pdt_taken;
    pdt_tag_i        = tag;
    which_pdt_i      = rand_word(1) != 0;
    history_i        = hist_t'(rand_word(HIST_LEN));

    taken   = ref_taken(exc, op, rs1, rs2);
    pdt_eff = pdt_taken && (tag == pc);
    cf      = ref_jump_type(exc) != JT_NONE;

    e.cyc             = cyc;
    e.result.pc       = pc;
    e.result.inst     = issue_i.inst;
    e.result.rd       = issue_i.rd;
    e.result.rs2_data = rs2;
    e.result.alu_data = ref_alu(exc, op, pc, rs1, rs2, imm);
    e.result.mem_op   = issue_i.mem_op;
    e.bpu_valid       = cf;
    e.bpu.taken       = taken;
    e.bpu.correct     = (taken == pdt_eff);
    e.bpu.jump_type   = ref_jump_type(exc);
    e.bpu.pc          = pc;
    e.bpu.target      = ref_target(exc, pc, rs1, imm);
    e.which_pdt       = which_pdt_i;
    e.history         = history_i;
    e.redirect        = ref_redirect(exc, taken, pdt_eff, check_en_exp);
    e.redirect_pc     = (pdt_eff && !taken) ? pc + 32'd4 : ref_target(exc, pc, rs1, imm);
    exp_q.push_back(e);

    if (cf) begin
      branch_tally = branch_tally + 1;
    end
    if (cf && taken != pdt_eff) begin
      miss_tally = miss_tally + 1;
    end
    @(negedge clk_i);
  endtask

  task automatic random_issue();
    exc_op_e exc;
    alu_op_e op;
    word_t   pc;
    word_t   rs1;
    word_t   rs2;
    word_t   imm;
    word_t   tag;
    logic    pdt;
    exc = exc_op_e'(rand_word(4) % 9 + 1);
    case (exc)
      EXC_OPREG, EXC_OPIMM: op = alu_op_e'(rand_word(4) % 10);
      EXC_BRANCH:           op = alu_op_e'(10 + rand_word(3) % 6);
      default:              op = alu_op_e'(rand_word(4));  // ignored by these classes
    endcase
    pc  = rand_word(30) << 2;
    rs1 = rand_word(32);
    rs2 = (rand_word(1) != 0) ? rs1 : rand_word(32);  // equal operands half the time
    imm = rand_word(32);
    pdt = rand_word(1) != 0;
    tag = (rand_word(1) != 0) ? pc : rand_word(32);
    issue_op(exc, op, pc, rs1, rs2, imm, pdt, tag);
  endtask

  task automatic idle(input int n);
    issue_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic write_check_en(input logic en);
    issue_valid_i  = 1'b0;
    cfg_we_i       = 1'b1;
    cfg_check_en_i = en;
    @(negedge clk_i);
    cfg_we_i     = 1'b0;
    check_en_exp = en;
  endtask

  task automatic drain_and_check_counts();
    issue_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);  // counters trail the feedback by one edge
    check("branch_count_o", branch_tally, branch_count_o);
    check("mispredict_count_o", miss_tally, mispredict_count_o);
  endtask

  // clear lands on the same edge that would count this branch
  task automatic clear_with_branch();
    issue_op(EXC_BRANCH, ALU_BGE, 32'h6000, 32'd3, 32'd3, 32'h10, 1'b0, '0);
    issue_valid_i = 1'b0;
    stats_clear_i = 1'b1;
    @(negedge clk_i);
    stats_clear_i = 1'b0;
    branch_tally  = '0;
    miss_tally    = '0;
  endtask

  always @(negedge clk_i) begin : compare_outputs
    expect_t e;
    logic    has_exp;
    has_exp = 1'b0;
    if (exp_q.size() != 0) begin
      has_exp = (exp_q[0].cyc == cyc - 1);
    end
    if (has_exp) begin
      e = exp_q.pop_front();
    end
    if (has_exp && result_valid_o !== 1'b1) begin
      n_errors++;
      $display("no result one cycle after the issue of cycle %0d (time %0t)", e.cyc, $time);
    end else if (!has_exp && result_valid_o !== 1'b0) begin
      n_errors++;
      $display("result_valid_o high at %0t with no issue pending", $time);
    end else if (has_exp) begin
      check("result_o", e.result, result_o);
      check("bpu_valid_o", e.bpu_valid, bpu_valid_o);
      if (e.bpu_valid) begin
        check("bpu_o", e.bpu, bpu_o);
      end
      check("which_pdt_o", e.which_pdt, which_pdt_o);
      check("history_o", e.history, history_o);
      check("redirect_valid_o", e.redirect, redirect_valid_o);
      if (e.redirect) begin
        check("redirect_pc_o", e.redirect_pc, redirect_pc_o);
      end
    end else begin
      check("bpu_valid_o", 1'b0, bpu_valid_o);
      check("redirect_valid_o", 1'b0, redirect_valid_o);
    end
  end

  initial begin : watchdog
    #((NUM_ISSUES + 200) * CLK_PERIOD);
    $display("timeout: the run did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_i          = 1'b1;
    issue_valid_i  = 1'b0;
    issue_i        = '0;
    pdt_taken_i    = 1'b0;
    pdt_tag_i      = '0;
    which_pdt_i    = 1'b0;
    history_i      = '0;
    cfg_we_i       = 1'b0;
    cfg_check_en_i = 1'b0;
    stats_clear_i  = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    // random mix with mostly back to back issues
    for (int i = 0; i < N_RAND; i++) begin
      random_issue();
      if (rand_word(2) == 0) begin
        idle(1);
      end
    end

    // plain op on a hit taken guess, jalr miss, taken guess not taken,
    // correct taken branch, jal with a tag miss
    issue_op(EXC_OPREG, ALU_ADD, 32'h1000, 32'd5, 32'd7, '0, 1'b1, 32'h1000);
    issue_op(EXC_JALR, ALU_ADD, 32'h2000, 32'h3001, 32'h3001, 32'h4, 1'b0, '0);
    issue_op(EXC_BRANCH, ALU_BEQ, 32'h3000, 32'd1, 32'd2, 32'h40, 1'b1, 32'h3000);
    issue_op(EXC_BRANCH, ALU_BLTU, 32'h4000, 32'd1, 32'd2, 32'h80, 1'b1, 32'h4000);
    issue_op(EXC_JAL, ALU_ADD, 32'h5000, '0, '0, 32'h100, 1'b1, 32'h5004);
    drain_and_check_counts();

    // with checking off the feedback goes on and redirects stop
    write_check_en(1'b0);
    repeat (N_OFF) random_issue();
    drain_and_check_counts();
    write_check_en(1'b1);

    clear_with_branch();
    drain_and_check_counts();
    repeat (2) random_issue();
    drain_and_check_counts();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
